/* lcdPkg.sv */
// LCD panel bus word type, command words and screen write sequence sizes for the display buffer
package lcdPkg;

	// one word on the 16-bit panel data bus
	typedef logic [15:0] pixel_t;

	// index of a write step within one frame
	typedef logic [17:0] step_t;

	// panel command words
	localparam pixel_t CMD_COLUMN = 16'h002A;
	localparam pixel_t CMD_PAGE = 16'h002B;
	localparam pixel_t CMD_MEMWRITE = 16'h002C;

	// words needed to move the cursor to (0,0)
	localparam int SETUP_STEPS = 7;

	// panel size in pixels, portrait orientation
	localparam int SCREEN_W = 240;
	localparam int SCREEN_H = 320;

	// one pixel word per screen position
	localparam int PIXEL_STEPS = SCREEN_W * SCREEN_H;

endpackage

/* gamePkg.sv */
// coin game geometry, colours, motion timing and coordinate types used by the pixel logic
package gamePkg;

	// unsigned screen coordinate
	typedef logic [10:0] coord_t;

	// signed displacement applied once per motion tick
	typedef logic signed [10:0] velocity_t;

	// side of the character and coin squares
	localparam int SPRITE_SIZE = 20;

	// background tile, repeated across the screen
	localparam int TILE_W = 60;
	localparam int TILE_H = 80;

	// memory address widths
	localparam int BG_ADDR_W = 13;
	localparam int PIC_ADDR_W = 12;

	// fixed colours
	localparam logic [15:0] COLOR_CHARACTER = 16'hF0FF;
	localparam logic [15:0] COLOR_OVERLAP = 16'h0000;

	// clock cycles between motion updates
	localparam int TICK_W = 20;
	localparam int TICK_CYCLES = 1 << TICK_W;

	// character reset position on both axes
	localparam int CHAR_START = 10;

endpackage

/* busArbiter.sv */
// panel ownership register and screen bus multiplexer between the CPU and the frame streamer
`timescale 1ns/1ps

module busArbiter
	import lcdPkg::*;
(
	input logic clk,
	input logic rst,
	input logic takeoverReq,
	input pixel_t cpuData,
	input logic cpuRs,
	input logic cpuCsN,
	input logic cpuWrN,
	input logic cpuRdN,
	input logic cpuResetN,
	input pixel_t seqData,
	input logic seqRs,
	input logic seqStrobeN,
	output logic bufferActive,
	output pixel_t lcdData,
	output logic lcdRs,
	output logic lcdCsN,
	output logic lcdWrN,
	output logic lcdRdN,
	output logic lcdResetN
);

	logic memWriteCmd;

	// the CPU announces a hand-over with the memory-write command word
	assign memWriteCmd = (cpuData == CMD_MEMWRITE) && !cpuRs && !cpuCsN;

	always_ff @(posedge clk)
	begin
		if (rst)
			bufferActive <= 1'b0;
		else if (memWriteCmd)
			bufferActive <= takeoverReq;
	end

	always_comb
	begin
		if (bufferActive)
		begin
			lcdData = seqData;
			lcdRs = seqRs;
			// chip select and write strobe move together
			lcdCsN = seqStrobeN;
			lcdWrN = seqStrobeN;
			lcdRdN = 1'b1;
		end
		else
		begin
			lcdData = cpuData;
			lcdRs = cpuRs;
			lcdCsN = cpuCsN;
			lcdWrN = cpuWrN;
			lcdRdN = cpuRdN;
		end
	end

	// panel reset stays with the CPU
	assign lcdResetN = cpuResetN;

endmodule

/* screenSequencer.sv */
// step counter that writes the cursor setup words and then one pixel word per screen position
`timescale 1ns/1ps

module screenSequencer
	import lcdPkg::*, gamePkg::*;
(
	input logic clk,
	input logic rst,
	input logic bufferActive,
	input pixel_t pixelColor,
	output pixel_t seqData,
	output logic seqRs,
	output logic seqStrobeN,
	output logic scanning,
	output coord_t pixelX,
	output coord_t pixelY,
	output logic pixelStrobe
);

	localparam step_t LAST_STEP = step_t'(SETUP_STEPS + PIXEL_STEPS - 1);

	step_t step;
	// low in the idle cycle, high in the strobe cycle of each step
	logic strobePhase;

	always_ff @(posedge clk)
	begin
		if (rst || !bufferActive)
		begin
			step <= '0;
			strobePhase <= 1'b0;
			pixelX <= '0;
			pixelY <= '0;
		end
		else if (!strobePhase)
			strobePhase <= 1'b1;
		else
		begin
			strobePhase <= 1'b0;
			if (step == LAST_STEP)
				step <= '0;
			else
				step <= step + step_t'(1);
			// advance the raster position after each pixel write
			if (scanning)
			begin
				if (pixelX == coord_t'(SCREEN_W - 1))
				begin
					pixelX <= '0;
					if (pixelY == coord_t'(SCREEN_H - 1))
						pixelY <= '0;
					else
						pixelY <= pixelY + coord_t'(1);
				end
				else
					pixelX <= pixelX + coord_t'(1);
			end
		end
	end

	assign scanning = (step >= step_t'(SETUP_STEPS));
	assign pixelStrobe = scanning && strobePhase;
	assign seqStrobeN = !strobePhase;

	// cursor setup: column command, two zero words, page command, two zero words, memory write
	always_comb
	begin
		seqData = pixelColor;
		seqRs = 1'b1;
		if (!scanning)
		begin
			case (step[2:0])
				3'd0:
				begin
					seqData = CMD_COLUMN;
					seqRs = 1'b0;
				end
				3'd3:
				begin
					seqData = CMD_PAGE;
					seqRs = 1'b0;
				end
				3'd6:
				begin
					seqData = CMD_MEMWRITE;
					seqRs = 1'b0;
				end
				default:
				begin
					seqData = '0;
					seqRs = 1'b1;
				end
			endcase
		end
	end

endmodule

/* spriteMotion.sv */
// slow tick that moves the character by its velocity and lets the coin drift across the screen
`timescale 1ns/1ps

module spriteMotion
	import lcdPkg::*, gamePkg::*;
(
	input logic clk,
	input logic rst,
	input logic bufferActive,
	input velocity_t charVx,
	input velocity_t charVy,
	input coord_t coinX0,
	input coord_t coinY0,
	output coord_t charX,
	output coord_t charY,
	output coord_t coinX,
	output coord_t coinY
);

	logic [TICK_W-1:0] tickCount;
	logic tick;

	// one step of the character, held between 0 and the far edge less the square
	function automatic coord_t clampMove(coord_t pos, velocity_t vel, int screenSize);
		logic signed [11:0] sum;
		sum = $signed({1'b0, pos}) + $signed({vel[10], vel});
		if (sum < 0)
			return '0;
		if (sum > screenSize - SPRITE_SIZE)
			return coord_t'(screenSize - SPRITE_SIZE);
		return coord_t'(sum);
	endfunction

	// coin moves one pixel and restarts near the origin at the far edge
	function automatic coord_t driftCoin(coord_t pos, int screenSize);
		if (pos + coord_t'(1) >= coord_t'(screenSize - SPRITE_SIZE))
			return coord_t'(SPRITE_SIZE + 1);
		return pos + coord_t'(1);
	endfunction

	always_ff @(posedge clk)
	begin
		if (rst)
			tickCount <= '0;
		else
			tickCount <= tickCount + 1'b1;
	end

	assign tick = (tickCount == TICK_W'(TICK_CYCLES - 1));

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			charX <= coord_t'(CHAR_START);
			charY <= coord_t'(CHAR_START);
		end
		else if (tick)
		begin
			charX <= clampMove(charX, charVx, SCREEN_W);
			charY <= clampMove(charY, charVy, SCREEN_H);
		end
	end

	// the CPU places the coin while it owns the panel
	always_ff @(posedge clk)
	begin
		if (rst || !bufferActive)
		begin
			coinX <= coinX0;
			coinY <= coinY0;
		end
		else if (tick)
		begin
			coinX <= driftCoin(coinX, SCREEN_W);
			coinY <= driftCoin(coinY, SCREEN_H);
		end
	end

endmodule

/* pixelComposer.sv */
// memory addressing, per-pixel colour choice and collision latch for the coin game picture
`timescale 1ns/1ps

module pixelComposer
	import lcdPkg::*, gamePkg::*;
(
	input logic clk,
	input logic rst,
	input logic bufferActive,
	input logic scanning,
	input logic pixelStrobe,
	input coord_t pixelX,
	input coord_t pixelY,
	input coord_t charX,
	input coord_t charY,
	input coord_t coinX,
	input coord_t coinY,
	input pixel_t bgData,
	input pixel_t picData,
	output logic [BG_ADDR_W-1:0] bgAddr,
	output logic bgEn,
	output logic [PIC_ADDR_W-1:0] picAddr,
	output logic picEn,
	output pixel_t pixelColor,
	output logic finish
);

	logic inChar;
	logic inCoin;
	coord_t coinOffX;
	coord_t coinOffY;
	logic collided;

	assign inChar = (pixelX >= charX) && (pixelX < charX + coord_t'(SPRITE_SIZE))
		&& (pixelY >= charY) && (pixelY < charY + coord_t'(SPRITE_SIZE));
	assign inCoin = (pixelX >= coinX) && (pixelX < coinX + coord_t'(SPRITE_SIZE))
		&& (pixelY >= coinY) && (pixelY < coinY + coord_t'(SPRITE_SIZE));

	// background tile repeats every TILE_W columns and TILE_H rows
	assign bgAddr = BG_ADDR_W'(pixelX % coord_t'(TILE_W))
		+ BG_ADDR_W'(TILE_W) * BG_ADDR_W'(pixelY % coord_t'(TILE_H));

	// position inside the coin picture, row by row
	assign coinOffX = pixelX - coinX;
	assign coinOffY = pixelY - coinY;
	assign picAddr = PIC_ADDR_W'(coinOffX) + PIC_ADDR_W'(SPRITE_SIZE) * PIC_ADDR_W'(coinOffY);

	// read in the idle cycle so the data is there for the strobe
	assign bgEn = scanning && !pixelStrobe;
	assign picEn = scanning && !pixelStrobe && inCoin;

	always_comb
	begin
		case ({inChar, inCoin})
			2'b11: pixelColor = COLOR_OVERLAP;
			2'b10: pixelColor = COLOR_CHARACTER;
			2'b01: pixelColor = picData;
			default: pixelColor = bgData;
		endcase
	end

	// an overlapped pixel written to the panel ends the game
	always_ff @(posedge clk)
	begin
		if (rst || !bufferActive)
			collided <= 1'b0;
		else if (pixelStrobe && inChar && inCoin)
			collided <= 1'b1;
	end

	assign finish = collided;

endmodule

/* lcdBuffer.sv */
// display buffer top that sits between the CPU panel bus and the LCD and draws the coin game
`timescale 1ns/1ps

module lcdBuffer
	import lcdPkg::*, gamePkg::*;
(
	input logic clk,
	input logic rst,
	input pixel_t cpuData,
	input logic cpuRs,
	input logic cpuCsN,
	input logic cpuWrN,
	input logic cpuRdN,
	input logic cpuResetN,
	input logic takeoverReq,
	input velocity_t charVx,
	input velocity_t charVy,
	input coord_t coinX0,
	input coord_t coinY0,
	input pixel_t bgData,
	input pixel_t picData,
	output pixel_t lcdData,
	output logic lcdRs,
	output logic lcdCsN,
	output logic lcdWrN,
	output logic lcdRdN,
	output logic lcdResetN,
	output logic [BG_ADDR_W-1:0] bgAddr,
	output logic bgEn,
	output logic [PIC_ADDR_W-1:0] picAddr,
	output logic picEn,
	output logic finish,
	output coord_t charX,
	output coord_t charY
);

	logic bufferActive;
	pixel_t seqData;
	logic seqRs;
	logic seqStrobeN;
	logic scanning;
	logic pixelStrobe;
	coord_t pixelX;
	coord_t pixelY;
	coord_t coinX;
	coord_t coinY;
	pixel_t pixelColor;

	busArbiter u_busArbiter (
		.clk(clk), .rst(rst), .takeoverReq(takeoverReq),
		.cpuData(cpuData), .cpuRs(cpuRs), .cpuCsN(cpuCsN), .cpuWrN(cpuWrN),
		.cpuRdN(cpuRdN), .cpuResetN(cpuResetN),
		.seqData(seqData), .seqRs(seqRs), .seqStrobeN(seqStrobeN),
		.bufferActive(bufferActive),
		.lcdData(lcdData), .lcdRs(lcdRs), .lcdCsN(lcdCsN), .lcdWrN(lcdWrN),
		.lcdRdN(lcdRdN), .lcdResetN(lcdResetN)
	);

	screenSequencer u_screenSequencer (
		.clk(clk), .rst(rst), .bufferActive(bufferActive), .pixelColor(pixelColor),
		.seqData(seqData), .seqRs(seqRs), .seqStrobeN(seqStrobeN), .scanning(scanning),
		.pixelX(pixelX), .pixelY(pixelY), .pixelStrobe(pixelStrobe)
	);

	spriteMotion u_spriteMotion (
		.clk(clk), .rst(rst), .bufferActive(bufferActive),
		.charVx(charVx), .charVy(charVy), .coinX0(coinX0), .coinY0(coinY0),
		.charX(charX), .charY(charY), .coinX(coinX), .coinY(coinY)
	);

	pixelComposer u_pixelComposer (
		.clk(clk), .rst(rst), .bufferActive(bufferActive),
		.scanning(scanning), .pixelStrobe(pixelStrobe), .pixelX(pixelX), .pixelY(pixelY),
		.charX(charX), .charY(charY), .coinX(coinX), .coinY(coinY),
		.bgData(bgData), .picData(picData),
		.bgAddr(bgAddr), .bgEn(bgEn), .picAddr(picAddr), .picEn(picEn),
		.pixelColor(pixelColor), .finish(finish)
	);

endmodule

/* lcdBuffer_assertions.sv */
// concurrent checks on the write strobe of the frame streamer, bound into screenSequencer
`timescale 1ns/1ps

module lcdBuffer_assertions
(
	input logic clk,
	input logic rst,
	input logic bufferActive,
	input logic seqStrobeN,
	input logic scanning,
	input logic pixelStrobe
);

	int failures = 0;

	// a strobe lasts one cycle and the next cycle is idle
	strobeThenIdle: assert property (@(posedge clk) disable iff (rst)
		!seqStrobeN |=> seqStrobeN)
	else
	begin
		$error("write strobe not followed by an idle cycle");
		failures++;
	end

	// the phase clears one clock after the CPU regains the panel
	idleWhileCpuOwns: assert property (@(posedge clk) disable iff (rst)
		!$past(bufferActive) |-> seqStrobeN)
	else
	begin
		$error("write strobe active while the CPU owns the panel");
		failures++;
	end

	// a pixel write follows the idle cycle of the same pixel step
	pixelOnlyWhileScanning: assert property (@(posedge clk) disable iff (rst)
		pixelStrobe |-> $past(scanning) && $past(seqStrobeN))
	else
	begin
		$error("pixel strobe outside the pixel stream");
		failures++;
	end

endmodule

bind screenSequencer lcdBuffer_assertions u_assertions (
	.clk(clk), .rst(rst), .bufferActive(bufferActive), .seqStrobeN(seqStrobeN),
	.scanning(scanning), .pixelStrobe(pixelStrobe)
);

/* tb_lcdBuffer.sv */
// directed testbench for the display buffer, run with the file list as top module tb_lcdBuffer
`timescale 1ns/1ps

module tb_lcdBuffer
	import lcdPkg::*, gamePkg::*;
();

	localparam int FRAME_CYCLES = 2 * (SETUP_STEPS + PIXEL_STEPS);
	// three frames of streaming plus two motion ticks, with slack for reset
	localparam int CYCLE_LIMIT = 3 * FRAME_CYCLES + 2 * TICK_CYCLES + 100;

	logic clk = 1'b0;
	logic rst;
	pixel_t cpuData;
	logic cpuRs, cpuCsN, cpuWrN, cpuRdN, cpuResetN, takeoverReq;
	velocity_t charVx, charVy;
	coord_t coinX0, coinY0, charX, charY;
	pixel_t bgData = '0;
	pixel_t picData = '0;
	pixel_t lcdData;
	logic lcdRs, lcdCsN, lcdWrN, lcdRdN, lcdResetN, bgEn, picEn, finish;
	logic [BG_ADDR_W-1:0] bgAddr;
	logic [PIC_ADDR_W-1:0] picAddr;
	integer seed;
	int cycles = 0;
	int checks = 0;
	int errors = 0;

	lcdBuffer u_lcdBuffer (.*);

	always #20 clk = ~clk;

	// synchronous memories with one cycle of read latency
	always @(posedge clk)
	begin
		if (bgEn)
			bgData <= pixel_t'(bgAddr) ^ 16'h5A00;
		if (picEn)
			picData <= pixel_t'(picAddr) + 16'h1000;
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("timeout: the run went past %0d clock cycles", CYCLE_LIMIT);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	task automatic compare(input string testName, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("** Error %s: expected %0h, actual %0h", testName, expected, actual);
		end
	endtask

	task automatic idleBus();
		cpuData = '0;
		cpuRs = 1'b1;
		cpuCsN = 1'b1;
		cpuWrN = 1'b1;
		cpuRdN = 1'b1;
		cpuResetN = 1'b1;
	endtask

	// one CPU write of the memory-write command, then the bus goes idle
	task automatic sendMemWrite(input logic request);
		cpuData = CMD_MEMWRITE;
		cpuRs = 1'b0;
		cpuCsN = 1'b0;
		cpuWrN = 1'b0;
		takeoverReq = request;
		@(negedge clk);
		idleBus();
	endtask

	// returns at the falling edge inside the next write strobe on the screen bus
	task automatic waitStrobe(input string testName);
		int waited;
		waited = 0;
		@(negedge clk);
		while (lcdCsN !== 1'b0 && waited < 3)
		begin
			@(negedge clk);
			waited++;
		end
		if (lcdCsN !== 1'b0)
		begin
			errors++;
			$display("%s: no write strobe on the screen bus within four cycles", testName);
		end
	endtask

	// expected colour with the character at its start position and the coin at (kx,ky)
	function automatic pixel_t colorOf(int x, int y, int kx, int ky);
		bit inChar;
		bit inCoin;
		inChar = x >= CHAR_START && x < CHAR_START + SPRITE_SIZE
			&& y >= CHAR_START && y < CHAR_START + SPRITE_SIZE;
		inCoin = x >= kx && x < kx + SPRITE_SIZE && y >= ky && y < ky + SPRITE_SIZE;
		if (inChar && inCoin)
			return COLOR_OVERLAP;
		if (inChar)
			return COLOR_CHARACTER;
		if (inCoin)
			return pixel_t'((x - kx) + SPRITE_SIZE * (y - ky) + 'h1000);
		return pixel_t'((x % TILE_W) + TILE_W * (y % TILE_H)) ^ 16'h5A00;
	endfunction

	task automatic passThroughTest();
		logic [31:0] word;
		int i;
		for (i = 0; i < 16; i++)
		begin
			word = $random(seed);
			cpuData = word[15:0];
			{cpuResetN, cpuRdN, cpuWrN, cpuCsN, cpuRs} = word[20:16];
			@(negedge clk);
			compare("passThrough data", 32'(word[15:0]), 32'(lcdData));
			compare("passThrough control", 32'(word[20:16]),
				32'({lcdResetN, lcdRdN, lcdWrN, lcdCsN, lcdRs}));
			compare("passThrough finish", 0, 32'(finish));
		end
		idleBus();
	endtask

	task automatic takeoverTest();
		pixel_t word;
		int i;
		sendMemWrite(1'b1);
		for (i = 0; i < SETUP_STEPS; i++)
		begin
			// commands at steps 0, 3 and 6 with zero arguments between them
			word = (i == 0) ? CMD_COLUMN : (i == 3) ? CMD_PAGE
				: (i == 6) ? CMD_MEMWRITE : 16'h0000;
			waitStrobe("takeover");
			compare("takeover rs and data", {15'd0, i % 3 != 0, word}, {15'd0, lcdRs, lcdData});
			compare("takeover write strobe", 0, 32'(lcdWrN));
		end
	endtask

	// every pixel of the first frame, coin at (100,150)
	task automatic pixelColorTest();
		int n;
		int x;
		int y;
		bit inCoin;
		// a CPU read level must not reach the panel while the buffer owns it
		cpuRdN = 1'b0;
		for (n = 0; n < PIXEL_STEPS; n++)
		begin
			x = n % SCREEN_W;
			y = n / SCREEN_W;
			inCoin = x >= 100 && x < 100 + SPRITE_SIZE && y >= 150 && y < 150 + SPRITE_SIZE;
			// idle cycle of the step, where both memories are read
			@(negedge clk);
			compare("pixelColor memory enables", {30'd0, 1'b1, inCoin}, {30'd0, bgEn, picEn});
			waitStrobe("pixelColor");
			compare("pixelColor", {15'd0, 1'b1, colorOf(x, y, 100, 150)},
				{15'd0, lcdRs, lcdData});
			compare("pixelColor read strobe", 1, 32'(lcdRdN));
		end
		cpuRdN = 1'b1;
	endtask

	task automatic frameLengthTest();
		int pixels;
		int i;
		bit restarted;
		pixels = 0;
		restarted = 1'b0;
		waitStrobe("frameLength");
		compare("frameLength restart", 32'(CMD_COLUMN), {15'd0, lcdRs, lcdData});
		for (i = 1; i < SETUP_STEPS; i++)
			waitStrobe("frameLength");
		while (!restarted && pixels <= PIXEL_STEPS)
		begin
			waitStrobe("frameLength");
			if (lcdRs == 1'b0 && lcdData == CMD_COLUMN)
				restarted = 1'b1;
			else
				pixels++;
		end
		compare("frameLength pixels", PIXEL_STEPS, pixels);
		compare("frameLength next frame", 1, 32'(restarted));
	endtask

	task automatic collisionTest();
		int waited;
		sendMemWrite(1'b0);
		coinX0 = coord_t'(15);
		coinY0 = coord_t'(15);
		@(negedge clk);
		compare("collision before takeover", 0, 32'(finish));
		sendMemWrite(1'b1);
		waited = 0;
		while (finish !== 1'b1 && waited < FRAME_CYCLES)
		begin
			@(negedge clk);
			waited++;
		end
		compare("collision within a frame", 1, 32'(finish));
		sendMemWrite(1'b0);
		@(negedge clk);
		compare("collision cleared", 0, 32'(finish));
	endtask

	task automatic waitCharMove();
		coord_t startX;
		coord_t startY;
		int waited;
		startX = charX;
		startY = charY;
		waited = 0;
		while (charX == startX && charY == startY && waited <= TICK_CYCLES)
		begin
			@(negedge clk);
			waited++;
		end
		if (waited > TICK_CYCLES)
		begin
			errors++;
			$display("motion: the character did not move within one motion tick");
		end
	endtask

	task automatic motionTest();
		charVx = 11'sd3;
		charVy = -11'sd2;
		waitCharMove();
		compare("motion x", 13, 32'(charX));
		compare("motion y", 8, 32'(charY));
		// far larger than the position, so both axes stop at the edge
		charVx = -11'sd500;
		charVy = -11'sd500;
		waitCharMove();
		compare("motion clamp x", 0, 32'(charX));
		compare("motion clamp y", 0, 32'(charY));
	endtask

	initial
	begin
		seed = 32'hec10_df34;
		rst = 1'b1;
		takeoverReq = 1'b0;
		charVx = '0;
		charVy = '0;
		coinX0 = coord_t'(100);
		coinY0 = coord_t'(150);
		idleBus();
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		passThroughTest();
		takeoverTest();
		pixelColorTest();
		frameLengthTest();
		collisionTest();
		motionTest();
		errors += u_lcdBuffer.u_screenSequencer.u_assertions.failures;
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

/* compile.f */
lcdPkg.sv
gamePkg.sv
busArbiter.sv
screenSequencer.sv
spriteMotion.sv
pixelComposer.sv
lcdBuffer.sv
lcdBuffer_assertions.sv
tb_lcdBuffer.sv

/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --assert -Wno-fatal
TOP = tb_lcdBuffer
FILELIST = compile.f
RUNFLAGS = +verilator+error+limit+1000
LOG = sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) $(RUNFLAGS) | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
